// File: uart_pkg.sv
//**************************************************
// UART transmitter shared constants
// Byte width, buffer depth, bit timing, FSM codes
//**************************************************

package uart_pkg;

	// Width of one byte, in the buffer and on the line
	localparam int DATA_W = 8;

	// Transmit buffer depth and its slot index width
	localparam int BUF_DEPTH = 16;
	localparam int PTR_W = $clog2(BUF_DEPTH);

	// Occupancy count, one bit wider so a full buffer fits
	localparam int COUNT_W = 5;

	// Clocks per serial bit, fixed at build time
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_W = $clog2(CLKS_PER_BIT);

	// Start + data + stop
	localparam int FRAME_BITS = 10;

	// Index of the data bit being sent
	localparam int BIT_IDX_W = $clog2(DATA_W);

	// Encoder FSM state codes
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_START = 2'd1;
	localparam logic [ST_W-1:0] ST_DATA = 2'd2;
	localparam logic [ST_W-1:0] ST_STOP = 2'd3;

endpackage

// File: tx_fifo_if.sv
//**************************************************
// Buffer to encoder link
// Head byte, occupancy, flags and the read strobe
//**************************************************

interface tx_fifo_if;
	import uart_pkg::*;

	// Byte at the head of the buffer
	logic [DATA_W-1:0] data;
	// Number of bytes held
	logic [COUNT_W-1:0] count;
	logic empty;
	logic full;
	// One-cycle read strobe from the encoder
	logic pop;

	// Buffer owns the data and the status
	modport buffer_side (
		output data,
		output count,
		output empty,
		output full,
		input  pop
	);

	// Encoder only needs the head byte and empty
	modport encoder_side (
		input  data,
		input  empty,
		output pop
	);

endinterface

// File: tx_buffer.sv
//**************************************************
// UART transmit buffer
// 16-byte shift register, head byte in slot 0
//**************************************************

module tx_buffer (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        wr,
	input  logic [uart_pkg::DATA_W-1:0] data_in,
	tx_fifo_if.buffer_side              fifo
);
	import uart_pkg::*;

	// Storage, slot 0 is the next byte to go out
	logic [DATA_W-1:0] buffer [BUF_DEPTH];

	// Occupancy, top bit set means full
	logic [COUNT_W-1:0] buffer_count;

	// Accepted write and accepted pop
	logic buffer_wren;
	logic buffer_pop;

	// Slot that the incoming byte lands in
	logic [PTR_W-1:0] wr_slot;

	// Writes while full are dropped here
	assign buffer_wren = wr && !fifo.full;

	// Pop ignored on an empty buffer
	assign buffer_pop = fifo.pop && !fifo.empty;

	// Status straight from the count
	assign fifo.full = buffer_count[COUNT_W-1];
	assign fifo.empty = (buffer_count == '0);
	assign fifo.count = buffer_count;

	// Head byte is visible without a clock
	assign fifo.data = buffer[0];

	// First free slot
	// on a simultaneous pop everything moves up one, so one slot earlier
	always_comb begin
		if (buffer_pop) begin
			wr_slot = PTR_W'(buffer_count - COUNT_W'(1));
		end else begin
			wr_slot = PTR_W'(buffer_count);
		end
	end

	// Occupancy count
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			buffer_count <= '0;
		end else begin
			// Push and pop together leave the count alone
			if (buffer_wren && !buffer_pop) begin
				buffer_count <= buffer_count + COUNT_W'(1);
			end else if (buffer_pop && !buffer_wren) begin
				buffer_count <= buffer_count - COUNT_W'(1);
			end
		end
	end

	// Shift register contents
	always_ff @(posedge CLK) begin
		if (buffer_pop) begin
			// Move every entry one place toward the head
			for (int i = 0; i < BUF_DEPTH - 1; i++) begin
				buffer[i] <= buffer[i+1];
			end
			// Tail slot is vacated
			buffer[BUF_DEPTH-1] <= '0;
		end
		// Later assignment wins over the shift for the same slot
		if (buffer_wren) begin
			buffer[wr_slot] <= data_in;
		end
	end

endmodule

// File: baud_gen.sv
//**************************************************
// Bit period counter
// One tick per bit, realigned at each frame start
//**************************************************

module baud_gen (
	input  logic CLK,
	input  logic nrst,
	input  logic restart,
	output logic tick
);
	import uart_pkg::*;

	// Clocks elapsed in the current bit
	logic [BAUD_W-1:0] baud_cnt;

	// Last clock of the bit period
	assign tick = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

	// Counter modulo CLKS_PER_BIT
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			baud_cnt <= '0;
		end else if (restart) begin
			// Frame start, first tick comes CLKS_PER_BIT cycles later
			baud_cnt <= '0;
		end else if (tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + BAUD_W'(1);
		end
	end

endmodule

// File: uart_encoder.sv
//**************************************************
// UART frame sequencer
// Pops bytes, sends start, 8 data LSB first, stop
//**************************************************

module uart_encoder (
	input  logic             CLK,
	input  logic             nrst,
	tx_fifo_if.encoder_side  fifo,
	input  logic             tick,
	output logic             restart,
	output logic             tx,
	output logic             busy
);
	import uart_pkg::*;

	// FSM state
	logic [ST_W-1:0] state;

	// Byte being shifted out, bit 0 is on the line
	logic [DATA_W-1:0] shift_reg;

	// Which data bit is on the line
	logic [BIT_IDX_W-1:0] bit_idx;

	// Frame launch, idle with a byte waiting
	logic launch;

	assign launch = (state == ST_IDLE) && !fifo.empty;

	// Pop and realign the bit timing in the same cycle
	assign fifo.pop = launch;
	assign restart = launch;

	// High from the edge after the pop to the end of the stop bit
	assign busy = (state != ST_IDLE);

	// Line level per state, idle high
	always_comb begin
		case (state)
			ST_START: tx = 1'b0;
			ST_DATA:  tx = shift_reg[0];
			default:  tx = 1'b1;
		endcase
	end

	// State and bit index
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			state <= ST_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// At least one idle cycle between frames
					if (launch) begin
						state <= ST_START;
						bit_idx <= '0;
					end
				end
				ST_START: begin
					if (tick) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (tick) begin
						// Last data bit done, go to stop
						if (bit_idx == BIT_IDX_W'(DATA_W - 1)) begin
							state <= ST_STOP;
						end
						bit_idx <= bit_idx + BIT_IDX_W'(1);
					end
				end
				ST_STOP: begin
					// Back to idle, empty is checked again there
					if (tick) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Byte capture and shift
	always_ff @(posedge CLK) begin
		if (launch) begin
			// Head byte taken in the pop cycle
			shift_reg <= fifo.data;
		end else if ((state == ST_DATA) && tick) begin
			// LSB first
			shift_reg <= shift_reg >> 1;
		end
	end

endmodule

// File: uart_tx.sv
//**************************************************
// UART transmitter top
// Buffer, frame encoder and bit timing
//**************************************************

module uart_tx (
	input  logic                         CLK,
	input  logic                         nrst,
	input  logic                         wr,
	input  logic [uart_pkg::DATA_W-1:0]  data_in,
	output logic                         tx,
	output logic                         busy,
	output logic [uart_pkg::COUNT_W-1:0] count,
	output logic                         buffer_full,
	output logic                         buffer_empty
);
	import uart_pkg::*;

	// Bit timing handshake between encoder and counter
	logic baud_tick;
	logic baud_restart;

	// Buffer to encoder link
	tx_fifo_if fifo_if_inst ();

	// Host writes land here
	tx_buffer buffer_inst (
		.CLK     (CLK),
		.nrst    (nrst),
		.wr      (wr),
		.data_in (data_in),
		.fifo    (fifo_if_inst.buffer_side)
	);

	// One tick per bit
	baud_gen baud_inst (
		.CLK     (CLK),
		.nrst    (nrst),
		.restart (baud_restart),
		.tick    (baud_tick)
	);

	// Drains the buffer onto the serial line
	uart_encoder encoder_inst (
		.CLK     (CLK),
		.nrst    (nrst),
		.fifo    (fifo_if_inst.encoder_side),
		.tick    (baud_tick),
		.restart (baud_restart),
		.tx      (tx),
		.busy    (busy)
	);

	// Buffer status to the host
	assign count = fifo_if_inst.count;
	assign buffer_full = fifo_if_inst.full;
	assign buffer_empty = fifo_if_inst.empty;

endmodule

// File: tb_clock.sv
//**************************************************
// Testbench clock and reset source
// 40 unit clock, reset low for 4 edges
//**************************************************

module tb_clock (
	output logic CLK,
	output logic nrst
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 4;

	// Free running clock
	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nrst <= 1'b1;
	end

endmodule

// File: tb_uart_tx.sv
//**************************************************
// UART transmitter testbench
// Reference queue, occupancy model and line sampler
//**************************************************

module tb_uart_tx;
	import uart_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam logic [31:0] SEED = 32'h2e85_6ffc;
	// Clocks from the pop edge to the end of the stop bit
	localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;
	localparam int BURST_BYTES = 16;
	localparam int OVERFLOW_BYTES = 24;
	localparam int PRELOAD_BYTES = 2;
	localparam int OVERLAP_BYTES = 10;
	localparam int TOTAL_BYTES = 1 + BURST_BYTES + OVERFLOW_BYTES
		+ PRELOAD_BYTES + OVERLAP_BYTES;
	localparam int WATCHDOG_TIME = (TOTAL_BYTES + 20) * FRAME_CLKS * CLK_PERIOD;

	logic CLK;
	logic nrst;
	logic wr;
	logic [DATA_W-1:0] data_in;
	logic tx;
	logic busy;
	logic [COUNT_W-1:0] count;
	logic buffer_full;
	logic buffer_empty;

	// Bytes accepted and not yet seen on the line
	logic [DATA_W-1:0] ref_q [$];
	// Model occupancy and clocks left in the current frame
	int model_count;
	int frame_left;
	int unsigned accepted_total;
	int unsigned overlap_total;
	string test_name;

	tb_clock clock_inst (
		.CLK  (CLK),
		.nrst (nrst)
	);

	uart_tx uart_tx_inst (
		.CLK          (CLK),
		.nrst         (nrst),
		.wr           (wr),
		.data_in      (data_in),
		.tx           (tx),
		.busy         (busy),
		.count        (count),
		.buffer_full  (buffer_full),
		.buffer_empty (buffer_empty)
	);

	task automatic stop_failed();
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		stop_failed();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		stop_failed();
	endtask

	// Line is high whenever no frame is running
	assert property (@(posedge CLK) disable iff (!nrst) (!busy |-> tx))
		else report_error("tx went low while the transmitter was idle");

	// Occupancy and frame timing model on pre-edge values
	always @(posedge CLK) begin : occupancy_model
		int next_count;
		int next_left;
		logic write_ok;
		if (!nrst) begin
			model_count <= 0;
			frame_left <= 0;
		end else begin
			assert (int'(count) == model_count)
				else report_mismatch("count", model_count, int'(count));
			assert (buffer_full == (model_count == BUF_DEPTH))
				else report_mismatch("buffer_full", int'(model_count == BUF_DEPTH),
					int'(buffer_full));
			assert (buffer_empty == (model_count == 0))
				else report_mismatch("buffer_empty", int'(model_count == 0),
					int'(buffer_empty));
			assert (busy == (frame_left != 0))
				else report_mismatch("busy", int'(frame_left != 0), int'(busy));
			// Idle cycle before any start bit
			if (frame_left == 0) begin
				assert (tx == 1'b1) else report_mismatch("idle line", 1, int'(tx));
			end
			// Start bit right after the pop edge
			if (frame_left == FRAME_CLKS) begin
				assert (tx == 1'b0) else report_mismatch("start bit edge", 0, int'(tx));
			end
			next_count = model_count;
			next_left = frame_left;
			write_ok = wr && (model_count != BUF_DEPTH);
			if (write_ok) begin
				next_count++;
				accepted_total++;
				ref_q.push_back(data_in);
			end
			// Encoder pops when idle and the buffer holds a byte
			if (frame_left == 0 && model_count != 0) begin
				next_count--;
				next_left = FRAME_CLKS;
				if (write_ok) begin
					overlap_total++;
				end
			end else if (frame_left != 0) begin
				next_left--;
			end
			model_count <= next_count;
			frame_left <= next_left;
		end
	end

	// Decode one frame at mid-bit points on the falling clock edge
	task automatic sample_frame();
		logic [DATA_W-1:0] rx_byte;
		logic [DATA_W-1:0] exp_byte;
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);
		assert (tx == 1'b0) else report_mismatch("start bit", 0, int'(tx));
		for (int i = 0; i < DATA_W; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			rx_byte[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		assert (tx == 1'b1) else report_mismatch("stop bit", 1, int'(tx));
		if (ref_q.size() == 0) begin
			report_error("a frame appeared on tx with no byte left to send");
		end else begin
			exp_byte = ref_q.pop_front();
			assert (rx_byte == exp_byte)
				else report_mismatch("frame data", int'(exp_byte), int'(rx_byte));
		end
	endtask

	initial begin : line_sampler
		wait (nrst === 1'b1);
		forever begin
			@(negedge tx);
			sample_frame();
		end
	end

	// Consecutive random writes with wr dropped after the last one
	task automatic write_burst(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge CLK);
			wr <= 1'b1;
			data_in <= DATA_W'($urandom);
		end
		@(posedge CLK);
		wr <= 1'b0;
	endtask

	task automatic write_one(input logic [DATA_W-1:0] b);
		@(posedge CLK);
		wr <= 1'b1;
		data_in <= b;
		@(posedge CLK);
		wr <= 1'b0;
	endtask

	// Place each write on the edge where the next frame pops
	task automatic write_at_frame_start(input int n);
		for (int i = 0; i < n; i++) begin
			do @(posedge CLK); while (frame_left != 1);
			wr <= 1'b1;
			data_in <= DATA_W'($urandom);
			@(posedge CLK);
			wr <= 1'b0;
		end
	endtask

	// Wait for every accepted byte to reach the line and some idle time after
	task automatic wait_drained();
		do @(posedge CLK);
		while (ref_q.size() != 0 || model_count != 0 || frame_left != 0);
		repeat (2 * CLKS_PER_BIT) @(posedge CLK);
	endtask

	initial begin : main_sequence
		int unsigned accepted_before;
		int unsigned overlap_before;
		wr = 1'b0;
		data_in = '0;
		accepted_total = 0;
		overlap_total = 0;
		test_name = "reset_state";
		void'($urandom(SEED));

		wait (nrst === 1'b1);
		@(negedge CLK);
		assert (tx == 1'b1) else report_mismatch("tx", 1, int'(tx));
		assert (busy == 1'b0) else report_mismatch("busy", 0, int'(busy));
		assert (count == '0) else report_mismatch("count", 0, int'(count));
		assert (buffer_empty == 1'b1)
			else report_mismatch("buffer_empty", 1, int'(buffer_empty));
		assert (buffer_full == 1'b0)
			else report_mismatch("buffer_full", 0, int'(buffer_full));
		// Line stays high while nothing is written
		repeat (4 * CLKS_PER_BIT) @(posedge CLK);

		test_name = "single_frame";
		write_one(8'hb4);
		wait_drained();

		test_name = "burst_order";
		write_burst(BURST_BYTES);
		wait_drained();

		// One byte leaves at the first pop and the rest fill the buffer
		test_name = "overflow_drop";
		accepted_before = accepted_total;
		write_burst(OVERFLOW_BYTES);
		wait_drained();
		assert (accepted_total - accepted_before == BUF_DEPTH + 1)
			else report_mismatch("accepted bytes", BUF_DEPTH + 1,
				int'(accepted_total - accepted_before));

		test_name = "write_during_pop";
		overlap_before = overlap_total;
		write_burst(PRELOAD_BYTES);
		write_at_frame_start(OVERLAP_BYTES);
		wait_drained();
		// Preload second byte also coincides with the first pop
		assert (overlap_total - overlap_before == OVERLAP_BYTES + 1)
			else report_mismatch("writes at pop", OVERLAP_BYTES + 1,
				int'(overlap_total - overlap_before));

		$display("All tests passed");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		report_error("simulation ran past its time limit without finishing");
	end

endmodule

// File: build.f
uart_pkg.sv
tx_fifo_if.sv
tx_buffer.sv
baud_gen.sv
uart_encoder.sv
uart_tx.sv
tb_clock.sv
tb_uart_tx.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the UART transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_tx \
	-f build.f \
	-o sim_uart_tx

# The simulator stops with a nonzero status on a failed check
./obj_dir/sim_uart_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1
